// ==== verilog/alu_cfg.svh ====
//----------------------------------------------------------------------
// Data word width and saturation limits for the fixed-point ALU
//----------------------------------------------------------------------
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Data path width
`define ALU_WIDTH   16

//----------------------------------------------------------------------
// Saturation values
//----------------------------------------------------------------------

// Result on positive overflow
`define ALU_MAX_POS 16'h7fff

`define ALU_MIN_NEG 16'h8000    // Result on negative overflow

`endif

// ==== verilog/alu_pkg.sv ====
//----------------------------------------------------------------------
// Opcode enum, data word type and the packed bundles used by the ALU
//----------------------------------------------------------------------
`include "alu_cfg.svh"

package alu_pkg;

    typedef logic [`ALU_WIDTH-1:0] alu_word_t;

    // Fixed-point opcodes
    typedef enum logic [4:0]
    {
        OP_ADD     = 5'd0,
        OP_ADD_CI  = 5'd1,
        OP_SUB     = 5'd2,
        OP_SUB_CI  = 5'd3,
        OP_AVG     = 5'd4,
        OP_COMP    = 5'd5,
        OP_AND     = 5'd6,
        OP_OR      = 5'd7,
        OP_XOR     = 5'd8,
        OP_NOT     = 5'd9,
        OP_REG_AND = 5'd10,
        OP_REG_OR  = 5'd11,
        OP_MIN     = 5'd12,
        OP_MAX     = 5'd13,
        OP_CLIP    = 5'd14,
        OP_ABS     = 5'd15,
        OP_PASS    = 5'd16
    } alu_op_e;

    // Execute-cycle control
    typedef struct packed
    {
        alu_op_e op;
        logic    sat;        // Saturate on overflow
        logic    ci;         // Carry in
    } alu_ctrl_t;

    // Output of one execution unit
    typedef struct packed
    {
        alu_word_t result;
        logic      av;
        logic      ac;
    } alu_unit_out_t;

    // Status flags
    typedef struct packed
    {
        logic az;            // Zero
        logic an;            // Negative
        logic ac;            // Carry
        logic av;            // Overflow
        logic as;            // Sign of x for ABS
        logic compd;         // Compare done pulse
    } alu_flags_t;

endpackage

// ==== verilog/alu_op_latch.sv ====
//----------------------------------------------------------------------
// Execute-stage register block: operands, control and enable strobe
//----------------------------------------------------------------------
`timescale 1ns/1ps

module alu_op_latch
(
    input  logic               clk,
    input  logic               reset,
    input  logic               alu_en,
    input  alu_pkg::alu_op_e   op,
    input  logic               sat,
    input  logic               ci,
    input  alu_pkg::alu_word_t x_in,
    input  alu_pkg::alu_word_t y_in,
    output alu_pkg::alu_ctrl_t ctrl,
    output alu_pkg::alu_word_t x,
    output alu_pkg::alu_word_t y,
    output logic               exec_valid
);

    //------------------------------------------------------------------
    // Strobe delay for the compare pulse
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            exec_valid <= 1'b0;
        end
        else
        begin
            exec_valid <= alu_en;
        end
    end

    //------------------------------------------------------------------
    // Operand and control capture
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            ctrl.op  <= alu_pkg::OP_PASS;   // Idle result is x = 0
            ctrl.sat <= 1'b0;
            ctrl.ci  <= 1'b0;
            x        <= '0;
            y        <= '0;
        end
        else if (alu_en)
        begin
            ctrl.op  <= op;
            ctrl.sat <= sat;
            ctrl.ci  <= ci;
            x        <= x_in;
            y        <= y_in;
        end
        // Otherwise hold for the execute cycle
    end

endmodule

// ==== verilog/alu_adder.sv ====
//----------------------------------------------------------------------
// Ripple-carry adder for the arithmetic opcodes, overflow and saturation
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_adder
(
    input  alu_pkg::alu_ctrl_t     ctrl,
    input  alu_pkg::alu_word_t     x,
    input  alu_pkg::alu_word_t     y,
    output alu_pkg::alu_unit_out_t add_out
);

    alu_pkg::alu_word_t  b_op;       // Second operand after inversion
    logic                c_in;
    alu_pkg::alu_word_t  sum;
    logic [`ALU_WIDTH:0] carry;
    logic                ovf;        // Signed overflow of the raw sum
    logic                av_eff;

    //------------------------------------------------------------------
    // Operand forming
    //------------------------------------------------------------------
    always_comb
    begin
        case (ctrl.op)
            alu_pkg::OP_ADD_CI:
            begin
                b_op = y;
                c_in = ctrl.ci;
            end
            alu_pkg::OP_SUB, alu_pkg::OP_COMP:
            begin
                b_op = ~y;
                c_in = 1'b1;            // Two's complement of y
            end
            alu_pkg::OP_SUB_CI:
            begin
                b_op = ~y;
                c_in = ctrl.ci;         // Borrow enters as carry
            end
            default:
            begin
                b_op = y;
                c_in = 1'b0;
            end
        endcase
    end

    // Carry chain, one full adder per bit
    always_comb
    begin
        carry[0] = c_in;
        for (int i = 0; i < `ALU_WIDTH; i++)
        begin
            sum[i]       = x[i] ^ b_op[i] ^ carry[i];
            carry[i + 1] = (x[i] & b_op[i]) | (x[i] & carry[i]) | (b_op[i] & carry[i]);
        end
    end

    assign ovf    = carry[`ALU_WIDTH] ^ carry[`ALU_WIDTH-1];
    assign av_eff = ovf && (ctrl.op != alu_pkg::OP_AVG) && (ctrl.op != alu_pkg::OP_COMP);

    //------------------------------------------------------------------
    // Result and saturation
    //------------------------------------------------------------------
    always_comb
    begin
        add_out.ac = carry[`ALU_WIDTH];
        add_out.av = av_eff;
        if (ctrl.op == alu_pkg::OP_AVG)
            add_out.result = {sum[`ALU_WIDTH-1], sum[`ALU_WIDTH-1:1]};  // Arithmetic halve
        else if (ctrl.sat && av_eff)
            // Wrapped sign is opposite to the true sign
            add_out.result = sum[`ALU_WIDTH-1] ? `ALU_MAX_POS : `ALU_MIN_NEG;
        else
            add_out.result = sum;
    end

endmodule

// ==== verilog/alu_logic_select.sv ====
//----------------------------------------------------------------------
// Bitwise, reducing, MIN/MAX, CLIP, ABS and PASS operations
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_logic_select
(
    input  alu_pkg::alu_ctrl_t     ctrl,
    input  alu_pkg::alu_word_t     x,
    input  alu_pkg::alu_word_t     y,
    output alu_pkg::alu_unit_out_t sel_out
);

    alu_pkg::alu_word_t mag_x;      // Magnitude of x, 8000 hex stays 8000
    alu_pkg::alu_word_t mag_y;
    logic               x_lt_y;     // Signed compare
    logic               clip_in;    // |x| below the clip limit

    //------------------------------------------------------------------
    // Magnitudes and compares
    //------------------------------------------------------------------
    assign mag_x   = x[`ALU_WIDTH-1] ? (~x + 1'b1) : x;
    assign mag_y   = y[`ALU_WIDTH-1] ? (~y + 1'b1) : y;
    assign x_lt_y  = $signed(x) < $signed(y);
    assign clip_in = mag_x < mag_y;     // Unsigned 16-bit magnitudes

    //------------------------------------------------------------------
    // Operation select
    //------------------------------------------------------------------
    always_comb
    begin
        sel_out.ac = 1'b0;              // No carry out of this unit
        sel_out.av = 1'b0;
        case (ctrl.op)
            alu_pkg::OP_AND:
                sel_out.result = x & y;
            alu_pkg::OP_OR:
                sel_out.result = x | y;
            alu_pkg::OP_XOR:
                sel_out.result = x ^ y;
            alu_pkg::OP_NOT:
                sel_out.result = ~x;
            alu_pkg::OP_REG_AND:
                sel_out.result = {{(`ALU_WIDTH-1){1'b0}}, &x};
            alu_pkg::OP_REG_OR:
                sel_out.result = {{(`ALU_WIDTH-1){1'b0}}, |x};
            alu_pkg::OP_MIN:
                sel_out.result = x_lt_y ? x : y;
            alu_pkg::OP_MAX:
                sel_out.result = x_lt_y ? y : x;
            alu_pkg::OP_CLIP:
            begin
                // Limit to |y|, keeping the sign of x
                if (clip_in)
                    sel_out.result = x;
                else if (x[`ALU_WIDTH-1])
                    sel_out.result = ~mag_y + 1'b1;
                else
                    sel_out.result = mag_y;
            end
            alu_pkg::OP_ABS:
            begin
                if (x == `ALU_MIN_NEG)
                begin
                    sel_out.av     = 1'b1;  // No positive counterpart
                    sel_out.result = ctrl.sat ? `ALU_MAX_POS : mag_x;
                end
                else
                begin
                    sel_out.result = mag_x;
                end
            end
            default:
                sel_out.result = x;     // PASS
        endcase
    end

endmodule

// ==== verilog/alu_result_flags.sv ====
//----------------------------------------------------------------------
// Result select by opcode class, status flags and compare strobe
//----------------------------------------------------------------------
`timescale 1ns/1ps

module alu_result_flags
(
    input  alu_pkg::alu_ctrl_t     ctrl,
    input  alu_pkg::alu_word_t     x,
    input  logic                   exec_valid,
    input  alu_pkg::alu_unit_out_t add_out,
    input  alu_pkg::alu_unit_out_t sel_out,
    output alu_pkg::alu_word_t     result,
    output alu_pkg::alu_flags_t    flags
);

    alu_pkg::alu_unit_out_t unit;
    logic                   use_adder;
    logic                   is_comp;

    // Opcode class decode
    always_comb
    begin
        case (ctrl.op)
            alu_pkg::OP_ADD, alu_pkg::OP_ADD_CI,
            alu_pkg::OP_SUB, alu_pkg::OP_SUB_CI,
            alu_pkg::OP_AVG, alu_pkg::OP_COMP:
                use_adder = 1'b1;
            default:
                use_adder = 1'b0;
        endcase
    end

    assign is_comp = (ctrl.op == alu_pkg::OP_COMP);
    assign unit    = use_adder ? add_out : sel_out;
    assign result  = unit.result;

    //------------------------------------------------------------------
    // Flags
    //------------------------------------------------------------------
    always_comb
    begin
        flags.az = (unit.result == '0);
        flags.an = unit.result[$bits(alu_pkg::alu_word_t)-1];
        flags.ac = unit.ac & ~is_comp;  // Compare reports no carry
        flags.av = unit.av;

        // Sign of x only for ABS
        if (ctrl.op == alu_pkg::OP_ABS)
            flags.as = x[$bits(alu_pkg::alu_word_t)-1];
        else
            flags.as = 1'b0;

        flags.compd = exec_valid & is_comp;   // One cycle after the accept
    end

endmodule

// ==== verilog/alu_top.sv ====
//----------------------------------------------------------------------
// Fixed-point ALU top level: operand latch and execution units
//----------------------------------------------------------------------
`timescale 1ns/1ps

module alu_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic                alu_en,
    input  alu_pkg::alu_op_e    op,
    input  logic                sat,
    input  logic                ci,
    input  alu_pkg::alu_word_t  x_in,
    input  alu_pkg::alu_word_t  y_in,
    output alu_pkg::alu_word_t  result,
    output alu_pkg::alu_flags_t flags
);

    alu_pkg::alu_ctrl_t     ctrl;
    alu_pkg::alu_word_t     x;
    alu_pkg::alu_word_t     y;
    logic                   exec_valid;
    alu_pkg::alu_unit_out_t add_out;   // Arithmetic unit
    alu_pkg::alu_unit_out_t sel_out;   // Logic and select unit

    //------------------------------------------------------------------
    // Execute-stage registers
    //------------------------------------------------------------------
    alu_op_latch u_latch
    (
        .clk        (clk),
        .reset      (reset),
        .alu_en     (alu_en),
        .op         (op),
        .sat        (sat),
        .ci         (ci),
        .x_in       (x_in),
        .y_in       (y_in),
        .ctrl       (ctrl),
        .x          (x),
        .y          (y),
        .exec_valid (exec_valid)
    );

    // Execution units
    alu_adder u_adder
    (
        .ctrl    (ctrl),
        .x       (x),
        .y       (y),
        .add_out (add_out)
    );

    alu_logic_select u_logic
    (
        .ctrl    (ctrl),
        .x       (x),
        .y       (y),
        .sel_out (sel_out)
    );

    alu_result_flags u_flags
    (
        .ctrl       (ctrl),
        .x          (x),
        .exec_valid (exec_valid),
        .add_out    (add_out),
        .sel_out    (sel_out),
        .result     (result),
        .flags      (flags)
    );

endmodule

// ==== verif/alu_properties.sv ====
//----------------------------------------------------------------------
// Assertions on the compare strobe, overflow flag and result hold
//----------------------------------------------------------------------
`timescale 1ns/1ps

module alu_properties
(
    input logic                clk,
    input logic                reset,
    input logic                alu_en,
    input alu_pkg::alu_op_e    op,
    input alu_pkg::alu_ctrl_t  ctrl,
    input alu_pkg::alu_word_t  result,
    input alu_pkg::alu_flags_t flags
);

    int unsigned fail_count = 0;    // Read by the testbench at the end

    // Compare strobe exactly one cycle after an accepted compare
    assert property (@(posedge clk) disable iff (!reset)
        flags.compd == $past(alu_en && op == alu_pkg::OP_COMP))
    else
    begin
        fail_count++;
        $error("compd does not follow an accepted compare");
    end

    assert property (@(posedge clk) disable iff (!reset)
        ctrl.op inside {alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR, alu_pkg::OP_NOT,
                        alu_pkg::OP_REG_AND, alu_pkg::OP_REG_OR, alu_pkg::OP_MIN,
                        alu_pkg::OP_MAX, alu_pkg::OP_CLIP, alu_pkg::OP_PASS} |-> !flags.av)
    else
    begin
        fail_count++;
        $error("av set for an opcode that cannot overflow");
    end

    // No capture, so no change
    assert property (@(posedge clk) disable iff (!reset) !alu_en |=> $stable(result))
    else
    begin
        fail_count++;
        $error("result changed without an enable");
    end

endmodule

bind alu_top alu_properties u_props
(
    .clk    (clk),
    .reset  (reset),
    .alu_en (alu_en),
    .op     (op),
    .ctrl   (ctrl),
    .result (result),
    .flags  (flags)
);

// ==== verif/alu_tb.sv ====
//----------------------------------------------------------------------
// ALU testbench: random stimulus, reference model, checks and timeout
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_tb;

    localparam int RESET_CYCLES   = 5;
    localparam int NUM_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = 2500;   // Reset and random run, with margin

    logic                clk;
    logic                reset;
    logic                alu_en;
    alu_pkg::alu_op_e    op;
    logic                sat;
    logic                ci;
    alu_pkg::alu_word_t  x_in;
    alu_pkg::alu_word_t  y_in;
    alu_pkg::alu_word_t  result;
    alu_pkg::alu_flags_t flags;

    // Model copy of the execute-stage registers
    alu_pkg::alu_op_e    m_op;
    logic                m_sat;
    logic                m_ci;
    alu_pkg::alu_word_t  m_x;
    alu_pkg::alu_word_t  m_y;
    logic                m_valid;

    int                  cycle_count = 0;
    int unsigned         seed_val;

    alu_top u_dut
    (
        .clk    (clk),
        .reset  (reset),
        .alu_en (alu_en),
        .op     (op),
        .sat    (sat),
        .ci     (ci),
        .x_in   (x_in),
        .y_in   (y_in),
        .result (result),
        .flags  (flags)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Cycle limit
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    //------------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------------
    function automatic alu_pkg::alu_word_t magnitude(input alu_pkg::alu_word_t w);
        return w[`ALU_WIDTH-1] ? (16'h0000 - w) : w;   // 8000 hex maps to itself
    endfunction

    function automatic void predict(output alu_pkg::alu_word_t  res,
                                    output alu_pkg::alu_flags_t flg);
        int          sx;
        int          sy;
        int          true_sum;
        logic [16:0] usum;
        logic        av;
        logic        ac;
        sx = int'($signed(m_x));
        sy = int'($signed(m_y));
        av = 1'b0;
        ac = 1'b0;
        usum = {1'b0, m_x} + {1'b0, m_y} + {16'd0, m_ci && m_op == alu_pkg::OP_ADD_CI};
        true_sum = sx + sy + int'(m_ci && m_op == alu_pkg::OP_ADD_CI);
        if (m_op inside {alu_pkg::OP_SUB, alu_pkg::OP_SUB_CI, alu_pkg::OP_COMP})
        begin
            // x - y, or x - y - 1 + ci for the borrow form
            usum = {1'b0, m_x} + {1'b0, ~m_y} + {16'd0, (m_op == alu_pkg::OP_SUB_CI) ? m_ci : 1'b1};
            true_sum = sx - sy - int'(m_op == alu_pkg::OP_SUB_CI && !m_ci);
        end
        case (m_op)
            alu_pkg::OP_ADD, alu_pkg::OP_ADD_CI, alu_pkg::OP_SUB, alu_pkg::OP_SUB_CI:
            begin
                ac  = usum[16];
                av  = (true_sum > 32767) || (true_sum < -32768);
                res = usum[15:0];
                if (av && m_sat)
                    res = (true_sum > 0) ? `ALU_MAX_POS : `ALU_MIN_NEG;
            end
            alu_pkg::OP_AVG:
            begin
                ac  = usum[16];
                res = $signed(usum[15:0]) >>> 1;
            end
            alu_pkg::OP_COMP:    res = usum[15:0];
            alu_pkg::OP_AND:     res = m_x & m_y;
            alu_pkg::OP_OR:      res = m_x | m_y;
            alu_pkg::OP_XOR:     res = m_x ^ m_y;
            alu_pkg::OP_NOT:     res = ~m_x;
            alu_pkg::OP_REG_AND: res = (m_x == 16'hffff) ? 16'd1 : 16'd0;
            alu_pkg::OP_REG_OR:  res = (m_x != 16'h0000) ? 16'd1 : 16'd0;
            alu_pkg::OP_MIN:     res = (sx < sy) ? m_x : m_y;
            alu_pkg::OP_MAX:     res = (sx > sy) ? m_x : m_y;
            alu_pkg::OP_CLIP:
                if (magnitude(m_x) < magnitude(m_y))
                    res = m_x;
                else
                    res = m_x[15] ? (16'h0000 - magnitude(m_y)) : magnitude(m_y);
            alu_pkg::OP_ABS:
            begin
                av  = (m_x == `ALU_MIN_NEG);
                res = (av && m_sat) ? `ALU_MAX_POS : magnitude(m_x);
            end
            default:             res = m_x;
        endcase
        flg.az    = (res == 16'h0000);
        flg.an    = res[15];
        flg.ac    = ac;
        flg.av    = av;
        flg.as    = (m_op == alu_pkg::OP_ABS) && m_x[15];
        flg.compd = (m_op == alu_pkg::OP_COMP) && m_valid;
    endfunction

    //------------------------------------------------------------------
    // Stimulus and checks
    //------------------------------------------------------------------
    function automatic alu_pkg::alu_word_t pick_operand();
        if ($urandom_range(99) >= 15)
            return alu_pkg::alu_word_t'($urandom);
        case ($urandom_range(3))
            0:       return 16'h0000;
            1:       return `ALU_MAX_POS;
            2:       return `ALU_MIN_NEG;
            default: return 16'hffff;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_outputs();
        alu_pkg::alu_word_t  exp_res;
        alu_pkg::alu_flags_t exp_flg;
        predict(exp_res, exp_flg);
        check_value("result", 32'(result), 32'(exp_res));
        check_value("flags", 32'(flags), 32'(exp_flg));
    endtask

    initial
    begin
        seed_val = $urandom(32'hdc55_1b01);
        reset  = 1'b0;
        alu_en = 1'b0;
        op     = alu_pkg::OP_PASS;
        sat    = 1'b0;
        ci     = 1'b0;
        x_in   = '0;
        y_in   = '0;
        m_op    = alu_pkg::OP_PASS;         // Reset state of the latch
        m_sat   = 1'b0;
        m_ci    = 1'b0;
        m_x     = '0;
        m_y     = '0;
        m_valid = 1'b0;

        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_outputs();
        end
        @(posedge clk);
        reset <= 1'b1;

        for (int n = 0; n < NUM_CYCLES; n++)
        begin
            @(posedge clk);
            // Inputs seen by the DUT at this edge
            m_valid = alu_en;
            if (alu_en)
            begin
                m_op  = op;
                m_sat = sat;
                m_ci  = ci;
                m_x   = x_in;
                m_y   = y_in;
            end
            alu_en <= ($urandom_range(99) < 70);
            op     <= alu_pkg::alu_op_e'($urandom_range(16));
            sat    <= 1'($urandom_range(1));
            ci     <= 1'($urandom_range(1));
            x_in   <= pick_operand();
            y_in   <= pick_operand();
            @(negedge clk);
            check_outputs();
        end

        if (u_dut.u_props.fail_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_op_latch.sv
verilog/alu_adder.sv
verilog/alu_logic_select.sv
verilog/alu_result_flags.sv
verilog/alu_top.sv
verif/alu_properties.sv
verif/alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module alu_tb -Mdir obj_dir -o alu_sim

./obj_dir/alu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
